// ==== dv/exu_patterns.txt ====
# opcode funct3 funct7 pc rs1 rs2 imm, then expected rd_data rd_we taken target illegal
# all columns hex, rd_data checked when rd_we is set, target for branch and jump only
33 0 00 1000 5 7 0 c 1 0 0 0
33 0 00 1000 7fffffffffffffff 1 0 8000000000000000 1 0 0 0
33 0 20 1000 0 1 0 ffffffffffffffff 1 0 0 0
33 0 20 1000 8000000000000000 1 0 7fffffffffffffff 1 0 0 0
33 4 00 1000 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f 0 0ff00ff00ff00ff0 1 0 0 0
33 6 00 1000 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f 0 0fff0fff0fff0fff 1 0 0 0
33 7 00 1000 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f 0 000f000f000f000f 1 0 0 0
13 0 00 1000 10 0 fffffffffffffff0 0 1 0 0 0
13 4 00 1000 1234 0 ffffffffffffffff ffffffffffffedcb 1 0 0 0
33 1 00 1000 8000000000000001 0 0 8000000000000001 1 0 0 0
33 1 00 1000 8000000000000001 1 0 2 1 0 0 0
13 1 01 1000 1 0 3f 8000000000000000 1 0 0 0
33 5 00 1000 8000000000000000 20 0 80000000 1 0 0 0
13 5 00 1000 8000000000000000 0 3f 1 1 0 0 0
33 5 20 1000 8000000000000000 1f 0 ffffffff00000000 1 0 0 0
13 5 20 1000 8000000000000000 0 1 c000000000000000 1 0 0 0
3b 1 00 1000 40000001 21 0 ffffffff80000002 1 0 0 0
3b 5 00 1000 80000000 0 0 ffffffff80000000 1 0 0 0
3b 5 00 1000 ffffffff80000000 1f 0 1 1 0 0 0
3b 5 20 1000 80000000 4 0 fffffffff8000000 1 0 0 0
1b 5 20 1000 80000000 0 1f ffffffffffffffff 1 0 0 0
3b 0 00 1000 7fffffff 1 0 ffffffff80000000 1 0 0 0
3b 0 20 1000 0 1 0 ffffffffffffffff 1 0 0 0
1b 0 00 1000 ffffffff00000005 0 fffffffffffffffd 2 1 0 0 0
33 2 00 1000 ffffffffffffffff 1 0 1 1 0 0 0
33 3 00 1000 ffffffffffffffff 1 0 0 1 0 0 0
13 2 00 1000 8000000000000000 0 7fffffffffffffff 1 1 0 0 0
63 0 00 2000 5 5 40 0 0 1 2040 0
63 1 00 2000 5 5 40 0 0 0 2040 0
63 4 00 2000 ffffffffffffffff 0 40 0 0 1 2040 0
63 5 00 2000 ffffffffffffffff 0 40 0 0 0 2040 0
63 6 00 2000 ffffffffffffffff 0 40 0 0 0 2040 0
63 7 00 2000 ffffffffffffffff 0 fffffffffffffff0 0 0 1 1ff0 0
6f 0 00 1000 0 0 100 1004 1 1 1100 0
67 0 00 1000 3001 0 10 1004 1 1 3010 0
37 0 00 1000 0 0 ffffffff80000000 ffffffff80000000 1 0 0 0
17 0 00 1000 0 0 12345000 12346000 1 0 0 0
03 0 00 1000 0 0 0 0 0 0 0 1
33 0 01 1000 3 4 0 0 0 0 0 1
3b 1 20 1000 1 1 0 0 0 0 0 1

// ==== flist.f ====
src/exu_pkg.sv
src/exu_alu_if.sv
src/alu_shift.sv
src/alu.sv
src/exu_issue.sv
src/exu_branch.sv
src/exu_top.sv
dv/tb_exu.sv

// ==== Makefile ====
TOP = tb_exu

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== dv/tb_exu.sv ====
`timescale 1ns/1ps

module tb_exu
  import exu_pkg::*;
();

  // expected response of one pattern
  typedef struct packed {
    logic [6:0]      opc;
    logic [XLEN-1:0] rd_data;
    logic            rd_we;
    logic            taken;
    logic [XLEN-1:0] target;
    logic            illegal;
  } expect_t;

  logic            clk_i;
  logic            rst_n_i;
  logic            in_valid_i;
  logic            in_ready_o;
  logic [6:0]      in_opcode_i;
  logic [2:0]      in_funct3_i;
  logic [6:0]      in_funct7_i;
  logic [XLEN-1:0] in_pc_i;
  logic [XLEN-1:0] in_rs1_i;
  logic [XLEN-1:0] in_rs2_i;
  logic [XLEN-1:0] in_imm_i;
  logic            out_ready_i;
  logic            out_valid_o;
  logic [XLEN-1:0] out_rd_data_o;
  logic            out_rd_we_o;
  logic            out_taken_o;
  logic [XLEN-1:0] out_target_o;
  logic            out_illegal_o;

  expect_t         exp_q [$];  // accepted, not yet consumed
  logic [31:0]     seed;
  logic            aborted;
  logic            drive_done;
  int              n_sent;
  int              n_recv;
  int              n_pass;
  int              err_cnt;

  exu_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic drive_patterns();
    int              fd;
    int              n;
    int              cnt;
    string           line;
    logic [XLEN-1:0] f [12];
    expect_t         e;
    fd = $fopen("dv/exu_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/exu_patterns.txt");
      aborted = 1'b1;
    end else begin
      while (!aborted && $fgets(line, fd) != 0) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                    f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
        if (n == 12) begin  // comment lines do not parse
          in_valid_i  <= 1'b1;
          in_opcode_i <= f[0][6:0];
          in_funct3_i <= f[1][2:0];
          in_funct7_i <= f[2][6:0];
          in_pc_i     <= f[3];
          in_rs1_i    <= f[4];
          in_rs2_i    <= f[5];
          in_imm_i    <= f[6];
          e.opc       = f[0][6:0];
          e.rd_data   = f[7];
          e.rd_we     = f[8][0];
          e.taken     = f[9][0];
          e.target    = f[10];
          e.illegal   = f[11][0];
          cnt = 0;
          @(posedge clk_i);
          while (!in_ready_o && cnt < 500) begin
            @(posedge clk_i);
            cnt++;
          end
          if (!in_ready_o) begin
            $display("timeout, instruction %0d never accepted", n_sent + 1);
            aborted = 1'b1;
          end else begin
            exp_q.push_back(e);
            n_sent++;
          end
        end
      end
      $fclose(fd);
    end
    in_valid_i <= 1'b0;
    drive_done = 1'b1;
  endtask

  task automatic check_results();
    expect_t             e;
    logic [2*XLEN+3:0]   held;
    logic [2*XLEN+3:0]   now;
    logic                stalled;
    int                  idle;
    int                  bad;
    stalled = 1'b0;
    held    = '0;
    idle    = 0;
    while (!aborted && !(drive_done && exp_q.size() == 0)) begin
      @(posedge clk_i);
      now = {out_valid_o, out_rd_data_o, out_rd_we_o, out_taken_o, out_target_o,
             out_illegal_o};
      if (stalled && now !== held) begin
        $display("error out_* bundle changed while stalled: held %h now %h", held, now);
        err_cnt++;
      end
      stalled = out_valid_o && !out_ready_i;
      held    = now;
      if (out_valid_o && out_ready_i) begin
        idle = 0;
        if (exp_q.size() == 0) begin
          $display("a result arrived with no instruction outstanding");
          err_cnt++;
        end else begin
          e   = exp_q.pop_front();
          bad = 0;
          if (out_rd_we_o !== e.rd_we) begin
            $display("error out_rd_we_o: got %h expected %h", out_rd_we_o, e.rd_we);
            bad++;
          end
          if (e.rd_we && out_rd_data_o !== e.rd_data) begin
            $display("error out_rd_data_o: got %h expected %h", out_rd_data_o, e.rd_data);
            bad++;
          end
          if (out_taken_o !== e.taken) begin
            $display("error out_taken_o: got %h expected %h", out_taken_o, e.taken);
            bad++;
          end
          // target only defined for control flow
          if (!e.illegal && e.opc inside {OPC_BRANCH, OPC_JAL, OPC_JALR} &&
              out_target_o !== e.target) begin
            $display("error out_target_o: got %h expected %h", out_target_o, e.target);
            bad++;
          end
          if (out_illegal_o !== e.illegal) begin
            $display("error out_illegal_o: got %h expected %h", out_illegal_o, e.illegal);
            bad++;
          end
          n_recv++;
          if (bad == 0) begin
            n_pass++;
            $display("pattern %0d ok", n_recv);
          end else begin
            $display("pattern %0d failed with %0d mismatches", n_recv, bad);
          end
          err_cnt += bad;
        end
      end else begin
        idle++;
        if (idle > 500) begin
          $display("timeout, no result consumed for 500 cycles");
          aborted = 1'b1;
        end
      end
      seed = lcg_next(seed);
      out_ready_i <= (seed[31:30] != 2'b00);  // ready about 3 cycles in 4
    end
  endtask

  initial begin
    rst_n_i     <= 1'b0;
    in_valid_i  <= 1'b0;
    in_opcode_i <= '0;
    in_funct3_i <= '0;
    in_funct7_i <= '0;
    in_pc_i     <= '0;
    in_rs1_i    <= '0;
    in_rs2_i    <= '0;
    in_imm_i    <= '0;
    out_ready_i <= 1'b0;
    seed        = 32'h44e2;
    aborted     = 1'b0;
    drive_done  = 1'b0;
    n_sent      = 0;
    n_recv      = 0;
    n_pass      = 0;
    err_cnt     = 0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    fork
      drive_patterns();
      check_results();
    join
    $display("%0d sent, %0d checked, %0d passed, %0d failed, %0d errors",
             n_sent, n_recv, n_pass, n_recv - n_pass, err_cnt);
    if (aborted || err_cnt != 0 || n_sent == 0 || n_recv != n_sent)
      $display("*** TEST FAILED ***");
    else
      $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== src/exu_top.sv ====
`timescale 1ns/1ps

module exu_top
  import exu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  logic [6:0]      in_opcode_i,
  input  logic [2:0]      in_funct3_i,
  input  logic [6:0]      in_funct7_i,
  input  logic [XLEN-1:0] in_pc_i,
  input  logic [XLEN-1:0] in_rs1_i,
  input  logic [XLEN-1:0] in_rs2_i,
  input  logic [XLEN-1:0] in_imm_i,
  input  logic            out_ready_i,
  output logic            out_valid_o,
  output logic [XLEN-1:0] out_rd_data_o,
  output logic            out_rd_we_o,
  output logic            out_taken_o,
  output logic [XLEN-1:0] out_target_o,
  output logic            out_illegal_o
);

  issue_t s1;
  logic   s1_valid;
  logic   s2_take;

  exu_alu_if alu_bus (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i)
  );

  exu_issue u_issue (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_opcode_i (in_opcode_i),
    .in_funct3_i (in_funct3_i),
    .in_funct7_i (in_funct7_i),
    .in_pc_i     (in_pc_i),
    .in_rs1_i    (in_rs1_i),
    .in_rs2_i    (in_rs2_i),
    .in_imm_i    (in_imm_i),
    .s2_take_i   (s2_take),
    .in_ready_o  (in_ready_o),
    .s1_valid_o  (s1_valid),
    .s1_o        (s1),
    .alu_bus     (alu_bus.issue)
  );

  alu u_alu (
    .alu_bus (alu_bus.exec)
  );

  exu_branch u_branch (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .s1_valid_i    (s1_valid),
    .s1_i          (s1),
    .alu_result_i  (alu_bus.result),
    .alu_cmp_i     (alu_bus.cmp),
    .rs1_i         (s1.rs1),
    .out_ready_i   (out_ready_i),
    .s2_take_o     (s2_take),
    .out_valid_o   (out_valid_o),
    .out_rd_data_o (out_rd_data_o),
    .out_rd_we_o   (out_rd_we_o),
    .out_taken_o   (out_taken_o),
    .out_target_o  (out_target_o),
    .out_illegal_o (out_illegal_o)
  );

endmodule

// ==== src/exu_branch.sv ====
`timescale 1ns/1ps

module exu_branch
  import exu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            s1_valid_i,
  input  issue_t          s1_i,
  input  logic [XLEN-1:0] alu_result_i,
  input  logic            alu_cmp_i,
  input  logic [XLEN-1:0] rs1_i,
  input  logic            out_ready_i,
  output logic            s2_take_o,
  output logic            out_valid_o,
  output logic [XLEN-1:0] out_rd_data_o,
  output logic            out_rd_we_o,
  output logic            out_taken_o,
  output logic [XLEN-1:0] out_target_o,
  output logic            out_illegal_o
);

  logic [XLEN-1:0] target;
  logic            taken;
  logic            valid_q;

  // jalr clears bit 0 of its target
  assign target = s1_i.is_jalr ? ((rs1_i + s1_i.imm) & ~{{(XLEN-1){1'b0}}, 1'b1})
                               : (s1_i.pc + s1_i.imm);
  assign taken  = s1_i.is_branch ? alu_cmp_i : s1_i.is_jump;

  assign s2_take_o = !valid_q || out_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (s2_take_o) begin
      valid_q <= s1_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s2_take_o && s1_valid_i) begin
      out_rd_data_o <= alu_result_i;
      out_rd_we_o   <= s1_i.rd_we;
      out_taken_o   <= taken;
      out_target_o  <= target;
      out_illegal_o <= s1_i.illegal;
    end
  end

  assign out_valid_o = valid_q;

  // held result while the consumer stalls
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o &&
      $stable({out_rd_data_o, out_rd_we_o, out_taken_o, out_target_o, out_illegal_o}));

endmodule

// ==== src/exu_issue.sv ====
`timescale 1ns/1ps

module exu_issue
  import exu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            in_valid_i,
  input  logic [6:0]      in_opcode_i,
  input  logic [2:0]      in_funct3_i,
  input  logic [6:0]      in_funct7_i,
  input  logic [XLEN-1:0] in_pc_i,
  input  logic [XLEN-1:0] in_rs1_i,
  input  logic [XLEN-1:0] in_rs2_i,
  input  logic [XLEN-1:0] in_imm_i,
  input  logic            s2_take_i,
  output logic            in_ready_o,
  output logic            s1_valid_o,
  output issue_t          s1_o,
  exu_alu_if.issue        alu_bus
);

  issue_t           s1_d, s1_q;
  logic [XLEN-1:0]  a_d, a_q;
  logic [XLEN-1:0]  b_d, b_q;
  logic             s1_valid_q;
  logic             accept;
  logic             bad;

  always_comb begin
    s1_d           = '0;
    s1_d.op        = ALU_ADD;
    s1_d.pc        = in_pc_i;
    s1_d.imm       = in_imm_i;
    s1_d.rs1       = in_rs1_i;
    s1_d.rd_we     = 1'b1;
    a_d            = in_rs1_i;
    b_d            = in_rs2_i;
    bad            = 1'b0;
    case (in_opcode_i)
      OPC_OP: begin
        case (in_funct3_i)
          3'b000:  s1_d.op = in_funct7_i[5] ? ALU_SUB : ALU_ADD;
          3'b001:  s1_d.op = ALU_SLL;
          3'b010:  s1_d.op = ALU_SLT;
          3'b011:  s1_d.op = ALU_SLTU;
          3'b100:  s1_d.op = ALU_XOR;
          3'b101:  s1_d.op = in_funct7_i[5] ? ALU_SRA : ALU_SRL;
          3'b110:  s1_d.op = ALU_OR;
          default: s1_d.op = ALU_AND;
        endcase
        // only sub and sra may carry funct7 bit 5
        if (in_funct7_i != 7'b0000000 &&
            !(in_funct7_i == 7'b0100000 && (in_funct3_i == 3'b000 || in_funct3_i == 3'b101)))
          bad = 1'b1;
      end
      OPC_OP_IMM: begin
        b_d = in_imm_i;
        case (in_funct3_i)
          3'b000:  s1_d.op = ALU_ADD;
          3'b010:  s1_d.op = ALU_SLT;
          3'b011:  s1_d.op = ALU_SLTU;
          3'b100:  s1_d.op = ALU_XOR;
          3'b110:  s1_d.op = ALU_OR;
          3'b111:  s1_d.op = ALU_AND;
          3'b001: begin
            s1_d.op = ALU_SLL;
            bad     = (in_funct7_i[6:1] != 6'b000000); // funct7[0] is shamt[5]
          end
          default: begin
            s1_d.op = in_funct7_i[5] ? ALU_SRA : ALU_SRL;
            bad     = (in_funct7_i[6:1] != 6'b000000) && (in_funct7_i[6:1] != 6'b010000);
          end
        endcase
      end
      OPC_OP_32, OPC_OP_IMM_32: begin
        if (in_opcode_i == OPC_OP_IMM_32)
          b_d = in_imm_i;
        case (in_funct3_i)
          3'b000: begin
            s1_d.op = (in_funct7_i[5] && in_opcode_i == OPC_OP_32) ? ALU_SUBW : ALU_ADDW;
            bad     = (in_opcode_i == OPC_OP_32) &&
                      (in_funct7_i != 7'b0000000) && (in_funct7_i != 7'b0100000);
          end
          3'b001: begin
            s1_d.op = ALU_SLLW;
            bad     = (in_funct7_i != 7'b0000000);
          end
          3'b101: begin
            s1_d.op = in_funct7_i[5] ? ALU_SRAW : ALU_SRLW;
            bad     = (in_funct7_i != 7'b0000000) && (in_funct7_i != 7'b0100000);
          end
          default: bad = 1'b1;
        endcase
        if (s1_d.op inside {ALU_SLLW, ALU_SRLW, ALU_SRAW})
          b_d = {{(XLEN-5){1'b0}}, b_d[4:0]}; // word shift count
      end
      OPC_BRANCH: begin
        s1_d.is_branch = 1'b1;
        s1_d.rd_we     = 1'b0;
        case (in_funct3_i)
          3'b000:  s1_d.op = ALU_BEQ;
          3'b001:  s1_d.op = ALU_BNE;
          3'b100:  s1_d.op = ALU_BLT;
          3'b101:  s1_d.op = ALU_BGE;
          3'b110:  s1_d.op = ALU_BLTU;
          3'b111:  s1_d.op = ALU_BGEU;
          default: bad = 1'b1;
        endcase
      end
      OPC_JAL, OPC_JALR: begin
        s1_d.is_jump = 1'b1;
        s1_d.is_jalr = (in_opcode_i == OPC_JALR);
        a_d          = in_pc_i;  // alu makes the link value
        b_d          = LINK_OFS;
        bad          = s1_d.is_jalr && (in_funct3_i != 3'b000);
      end
      OPC_LUI: begin
        a_d = '0;
        b_d = in_imm_i;
      end
      OPC_AUIPC: begin
        a_d = in_pc_i;
        b_d = in_imm_i;
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      s1_d.illegal   = 1'b1;
      s1_d.rd_we     = 1'b0;
      s1_d.is_branch = 1'b0;
      s1_d.is_jump   = 1'b0;
      s1_d.is_jalr   = 1'b0;
    end
  end

  assign in_ready_o = !s1_valid_q || s2_take_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
    end else if (accept) begin
      s1_valid_q <= 1'b1;
    end else if (s2_take_i) begin
      s1_valid_q <= 1'b0;  // moved on to stage 2
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      s1_q <= s1_d;
      a_q  <= a_d;
      b_q  <= b_d;
    end
  end

  assign s1_valid_o  = s1_valid_q;
  assign s1_o        = s1_q;
  assign alu_bus.op  = s1_q.op;
  assign alu_bus.a   = a_q;
  assign alu_bus.b   = b_q;

  // a stalled stage 1 must not be overwritten
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s1_valid_o && !s2_take_i |=> s1_valid_o && $stable(s1_o));

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu
  import exu_pkg::*;
(
  exu_alu_if.exec alu_bus
);

  logic             is_cmp;
  logic             is_sub;
  logic [XLEN:0]    a_ext;
  logic [XLEN:0]    b_ext;
  logic [XLEN:0]    sum;
  logic             zero;
  logic             ovf;
  logic             carry;
  logic             lt_s;
  logic             lt_u;
  logic             cmp_flag;
  logic             is_word;
  shift_kind_e      sh_kind;
  logic [XLEN-1:0]  sh_res;
  logic [XLEN-1:0]  res;

  assign is_cmp = alu_bus.op inside {ALU_SLT, ALU_SLTU, ALU_BEQ, ALU_BNE,
                                     ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};
  assign is_sub = is_cmp || (alu_bus.op inside {ALU_SUB, ALU_SUBW});

  // double sign bit adder, invert and add one for subtract
  assign a_ext = {alu_bus.a[XLEN-1], alu_bus.a};
  assign b_ext = {alu_bus.b[XLEN-1], alu_bus.b} ^ {(XLEN+1){is_sub}};
  assign sum   = a_ext + b_ext + {{XLEN{1'b0}}, is_sub};

  assign zero  = (sum[XLEN-1:0] == '0);
  assign ovf   = sum[XLEN] ^ sum[XLEN-1];               // sign bits disagree
  assign carry = sum[XLEN] ^ a_ext[XLEN] ^ b_ext[XLEN]; // carry out of bit 63
  assign lt_s  = sum[XLEN-1] ^ ovf;
  assign lt_u  = ~carry;                                // borrow

  always_comb begin
    case (alu_bus.op)
      ALU_SLT, ALU_BLT:   cmp_flag = lt_s;
      ALU_SLTU, ALU_BLTU: cmp_flag = lt_u;
      ALU_BEQ:            cmp_flag = zero;
      ALU_BNE:            cmp_flag = ~zero;
      ALU_BGE:            cmp_flag = ~lt_s;
      ALU_BGEU:           cmp_flag = ~lt_u;
      default:            cmp_flag = 1'b0;
    endcase
  end

  always_comb begin
    case (alu_bus.op)
      ALU_SLL, ALU_SLLW: sh_kind = SH_SLL;
      ALU_SRL, ALU_SRLW: sh_kind = SH_SRL;
      ALU_SRA, ALU_SRAW: sh_kind = SH_SRA;
      default:           sh_kind = SH_NONE;
    endcase
  end
  assign is_word = alu_bus.op inside {ALU_SLLW, ALU_SRLW, ALU_SRAW};

  alu_shift u_alu_shift (
    .shift_kind_i (sh_kind),
    .word_i       (is_word),
    .num_i        (alu_bus.a),
    .count_i      (alu_bus.b[5:0]),
    .shift_o      (sh_res)
  );

  always_comb begin
    case (alu_bus.op)
      ALU_ADD, ALU_SUB:   res = sum[XLEN-1:0];
      ALU_ADDW, ALU_SUBW: res = {{(XLEN-32){sum[31]}}, sum[31:0]};
      ALU_XOR:            res = alu_bus.a ^ alu_bus.b;
      ALU_OR:             res = alu_bus.a | alu_bus.b;
      ALU_AND:            res = alu_bus.a & alu_bus.b;
      ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_SLLW, ALU_SRLW, ALU_SRAW: res = sh_res;
      default:            res = {{(XLEN-1){1'b0}}, cmp_flag}; // compares
    endcase
  end

  assign alu_bus.result = res;
  assign alu_bus.cmp    = cmp_flag;

  // branch logic relies on cmp being quiet outside compares
  assert property (@(posedge alu_bus.clk_i) disable iff (!alu_bus.rst_n_i)
    !is_cmp |-> !alu_bus.cmp);

endmodule

// ==== src/alu_shift.sv ====
`timescale 1ns/1ps

module alu_shift
  import exu_pkg::*;
(
  input  shift_kind_e     shift_kind_i,
  input  logic            word_i,
  input  logic [XLEN-1:0] num_i,
  input  logic [5:0]      count_i,
  output logic [XLEN-1:0] shift_o
);

  logic [XLEN-1:0] num;
  logic [XLEN-1:0] shl_in;
  logic [XLEN-1:0] shl_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;
  logic [XLEN-1:0] mask;
  logic [5:0]      mask_cnt;
  logic            sign;
  logic            is_right;
  logic [XLEN-1:0] res;

  function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] v);
    logic [XLEN-1:0] r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = v[XLEN-1-i];
    end
    return r;
  endfunction

  assign num      = word_i ? {{(XLEN-32){1'b0}}, num_i[31:0]} : num_i; // drop upper word
  assign is_right = (shift_kind_i == SH_SRL) || (shift_kind_i == SH_SRA);

  // one left shifter serves both directions
  assign shl_in  = is_right ? bit_rev(num) : num;
  assign shl_res = shl_in << count_i;
  assign srl_res = bit_rev(shl_res);

  // sign fill above the surviving bits
  assign mask_cnt = word_i ? (count_i + 6'd32) : count_i;
  assign mask     = {XLEN{1'b1}} >> mask_cnt;
  assign sign     = word_i ? num_i[31] : num_i[XLEN-1];
  assign sra_res  = (srl_res & mask) | ({XLEN{sign}} & ~mask);

  always_comb begin
    case (shift_kind_i)
      SH_SLL:  res = shl_res;
      SH_SRL:  res = srl_res;
      SH_SRA:  res = sra_res;
      default: res = '0;
    endcase
  end

  assign shift_o = word_i ? {{(XLEN-32){res[31]}}, res[31:0]} : res;

endmodule

// ==== src/exu_alu_if.sv ====
`timescale 1ns/1ps

interface exu_alu_if
  import exu_pkg::*;
(
  input logic clk_i,
  input logic rst_n_i
);

  alu_op_e          op;
  logic [XLEN-1:0]  a;
  logic [XLEN-1:0]  b;
  logic [XLEN-1:0]  result;
  logic             cmp;

  // issue side owns the operands
  modport issue (
    output op, a, b,
    input  result, cmp
  );

  // combinational alu, clock and reset only for checks
  modport exec (
    input  clk_i, rst_n_i,
    input  op, a, b,
    output result, cmp
  );

endinterface

// ==== src/exu_pkg.sv ====
package exu_pkg;

  localparam int XLEN = 64;

  // link value is pc of the next sequential instruction
  localparam logic [XLEN-1:0] LINK_OFS = XLEN'(4);

  // rv major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP_32     = 7'b0111011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_BRANCH    = 7'b1100011,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_ADDW,
    ALU_SUBW,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLLW,
    ALU_SRLW,
    ALU_SRAW,
    ALU_SLT,
    ALU_SLTU,
    ALU_BEQ,   // branch compares, result only on cmp
    ALU_BNE,
    ALU_BLT,
    ALU_BGE,
    ALU_BLTU,
    ALU_BGEU
  } alu_op_e;

  // shifter control, none forces a zero result
  typedef enum logic [1:0] {
    SH_NONE,
    SH_SLL,
    SH_SRL,
    SH_SRA
  } shift_kind_e;

  // stage 1 contents besides the alu operands
  typedef struct packed {
    alu_op_e          op;
    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  imm;
    logic [XLEN-1:0]  rs1;        // kept for the jalr target
    logic             is_branch;
    logic             is_jump;
    logic             is_jalr;
    logic             rd_we;
    logic             illegal;
  } issue_t;

endpackage
